/* dv/board_stim.txt */
# op name addr data pad expected, numbers in hex
# pad op: addr 0 pad_out, 1 pad_oe, 2 {tdi,tms,tck}, data bit 0 drives TDO; wait with data 0 polls idle
read  rst_gpio_out    0 0        0      0
read  rst_gpio_oe     1 0        0      0
read  rst_key         2 0        0      0
read  rst_data        3 0        0      0
read  rst_result      5 0        0      0
read  rst_status      7 0        0      1
pad   rst_pad_oe      1 0        0      0
write gpio_out_wr     0 000a5a3c 0      0
write gpio_oe_wr      1 001fffff 0      0
read  gpio_out_rd     0 0        0      000a5a3c
pad   gpio_pad_out    0 0        0      000a5a3c
pad   gpio_pad_oe     1 0        0      001fffff
read  gpio_in_rd      6 0        0ac3e5 000ac3e5
write lat_key         2 00000001 0      0
write lat_data        3 12345678 0      0
write lat_start       4 1        0      0
wait  lat_wait        0 7        0      0
read  lat_busy        7 0        0      0
read  lat_idle        7 0        0      1
read  lat_result      5 0        0      345679ec
write bp_key          2 80000000 0      0
write bp_data         3 cafef00d 0      0
write bp_start        4 1        0      0
pad   trig_clr_busy   0 0        0      000a5a3c
write bp_data_busy    3 11111111 0      0
write bp_restart      4 1        0      0
wait  bp_poll         0 0        0      0
read  bp_result       5 0        0      fef00d35
write trig_gpio_on    0 000ada3c 0      0
pad   trig_idle       0 0        0      000a5a3c
write trig_start      4 1        0      0
pad   trig_busy       0 0        0      000ada3c
read  trig_status     7 0        0      0
pad   trig_busy_late  0 0        0      000ada3c
wait  trig_poll       0 0        0      0
pad   trig_done       0 0        0      000a5a3c
read  trig_result     5 0        0      fef00d35
pad   jtag_pins       2 0        0f0000 7
pad   jtag_tdo_hi     0 1        010000 001a5a3c
pad   jtag_tdo_lo     0 0        010000 000a5a3c
pad   jtag_pad_oe     1 0        010000 0011ffff
read  jtag_gpio_in    6 0        1f00ff 000500ff
pad   jtag_rest       2 0        0e0000 2
read  gpio_in_nojtag  6 0        1e00ff 001e00ff
rand  rand_run_0      0 0        0      0
rand  rand_run_1      0 0        0      0

/* dv/board_top_assert.sv */
////////////////////
// Bound into board_top, checks the JTAG overlay and the trigger window
// fail_cnt is read back by the testbench at the end of the run
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module board_top_assert (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic [`BOARD_NUM_PADS-1:0] pad_in_i,
  input logic [`BOARD_NUM_PADS-1:0] pad_out_i,
  input logic [`BOARD_NUM_PADS-1:0] pad_oe_i,
  input logic                       jtag_tck_i,
  input logic                       cipher_idle_i
);

  int fail_cnt = 0;

  // TDO is driven and TCK follows its pad whenever the strap selects JTAG
  assert property (@(posedge clk_i) disable iff (rst_i)
    pad_in_i[`BOARD_JTAG_EN_IDX] |->
      pad_oe_i[`BOARD_TDO_IDX] && (jtag_tck_i == pad_in_i[`BOARD_TCK_IDX]))
    else begin
      fail_cnt++;
      $error("JTAG overlay: TDO not driven or TCK not following its pad");
    end

  assert property (@(posedge clk_i) disable iff (rst_i)
    cipher_idle_i |-> !pad_out_i[`BOARD_TRIGGER_IDX])
    else begin
      fail_cnt++;
      $error("Capture trigger high while the cipher is idle");
    end

  // Busy window is exactly one round per cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cipher_idle_i) |->
      $past(cipher_idle_i, `BOARD_ROUNDS + 1) && !$past(cipher_idle_i, `BOARD_ROUNDS))
    else begin
      fail_cnt++;
      $error("Cipher busy window differs from the round count");
    end

endmodule : board_top_assert

/* dv/tb_board_top.sv */
////////////////////
// Testbench for board_top, stimulus and expected values from dv/board_stim.txt
// Must run from the project root so the stimulus path resolves
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module tb_board_top;

  import board_pkg::*;

  localparam int clk_period = 40;
  localparam int max_lines  = 64;
  localparam int poll_limit = `BOARD_ROUNDS + 4;

  logic                       clk;
  logic                       rst;
  logic [`BOARD_NUM_PADS-1:0] pad_in;
  logic [`BOARD_NUM_PADS-1:0] pad_out;
  logic [`BOARD_NUM_PADS-1:0] pad_oe;
  logic                       reg_we;
  reg_addr_e                  reg_addr;
  logic [`BOARD_DW-1:0]       reg_wdata;
  logic [`BOARD_DW-1:0]       reg_rdata;
  logic                       jtag_tck;
  logic                       jtag_tms;
  logic                       jtag_tdi;
  logic                       jtag_tdo;

  // Stimulus table, one entry per data line
  logic [8*8-1:0]  op_tab   [max_lines];
  logic [8*24-1:0] name_tab [max_lines];
  logic [31:0]     addr_tab [max_lines];
  logic [31:0]     data_tab [max_lines];
  logic [31:0]     pad_tab  [max_lines];
  logic [31:0]     exp_tab  [max_lines];
  int              n_lines  = 0;
  int              n_tests  = 0;
  int              n_errors = 0;
  bit              test_ok;

  board_top dut_i (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .pad_in_i    ( pad_in    ),
    .pad_out_o   ( pad_out   ),
    .pad_oe_o    ( pad_oe    ),
    .reg_we_i    ( reg_we    ),
    .reg_addr_i  ( reg_addr  ),
    .reg_wdata_i ( reg_wdata ),
    .reg_rdata_o ( reg_rdata ),
    .jtag_tck_o  ( jtag_tck  ),
    .jtag_tms_o  ( jtag_tms  ),
    .jtag_tdi_o  ( jtag_tdi  ),
    .jtag_tdo_i  ( jtag_tdo  )
  );

  bind board_top board_top_assert u_board_top_assert (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .pad_in_i      ( pad_in_i    ),
    .pad_out_i     ( pad_out_o   ),
    .pad_oe_i      ( pad_oe_o    ),
    .jtag_tck_i    ( jtag_tck_o  ),
    .cipher_idle_i ( cipher_idle )
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Reference cipher, XOR with key then rotate left once per round
  function automatic logic [31:0] cipher_model(input logic [31:0] key, input logic [31:0] data);
    logic [31:0] s;
    s = data;
    for (int r = 0; r < `BOARD_ROUNDS; r++) begin
      s = s ^ key;
      s = {s[30:0], s[31]};
    end
    return s;
  endfunction

  task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Error: %0s expected %h actual %h", name, exp_val, act_val);
      n_errors++;
      test_ok = 1'b0;
    end
  endtask

  // Inputs change on the rising edge, outputs are sampled on the falling edge
  task automatic drive_cycle(input logic we, input reg_addr_e addr, input logic [31:0] wdata,
                             input logic [31:0] pad, input logic tdo);
    @(posedge clk);
    reg_we    <= we;
    reg_addr  <= addr;
    reg_wdata <= wdata;
    pad_in    <= pad[`BOARD_NUM_PADS-1:0];
    jtag_tdo  <= tdo;
    @(negedge clk);
  endtask

  task automatic wait_idle(input logic [8*24-1:0] name, input logic [31:0] pad);
    bit done;
    done = 1'b0;
    for (int n = 0; n < poll_limit && !done; n++) begin
      drive_cycle(1'b0, ADDR_STATUS, '0, pad, 1'b0);
      done = reg_rdata[0];
    end
    if (!done) begin
      $display("%0s: cipher still busy after %0d status polls", name, poll_limit);
      n_errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic run_random(input logic [8*24-1:0] name);
    logic [31:0] key;
    logic [31:0] data;
    key  = $urandom();
    data = $urandom();
    drive_cycle(1'b1, ADDR_KEY, key, '0, 1'b0);
    drive_cycle(1'b1, ADDR_DATA, data, '0, 1'b0);
    drive_cycle(1'b1, ADDR_CTRL, 32'h1, '0, 1'b0);
    wait_idle(name, '0);
    drive_cycle(1'b0, ADDR_RESULT, '0, '0, 1'b0);
    check_value(name, cipher_model(key, data), reg_rdata);
  endtask

  task automatic load_stimulus();
    int              fd;
    int              n;
    string           line;
    logic [8*8-1:0]  op;
    logic [8*24-1:0] name;
    logic [31:0]     a;
    logic [31:0]     d;
    logic [31:0]     p;
    logic [31:0]     e;
    fd = $fopen("dv/board_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/board_stim.txt");
    end else begin
      while (!$feof(fd) && n_lines < max_lines) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %h %h", op, name, a, d, p, e);
          if (n == 6) begin
            op_tab[n_lines]   = op;
            name_tab[n_lines] = name;
            addr_tab[n_lines] = a;
            data_tab[n_lines] = d;
            pad_tab[n_lines]  = p;
            exp_tab[n_lines]  = e;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input int i);
    logic [31:0] act;
    test_ok = 1'b1;
    act     = '0;
    case (op_tab[i])
      "write": drive_cycle(1'b1, reg_addr_e'(addr_tab[i][2:0]), data_tab[i], pad_tab[i], 1'b0);
      "read": begin
        drive_cycle(1'b0, reg_addr_e'(addr_tab[i][2:0]), '0, pad_tab[i], 1'b0);
        check_value(name_tab[i], exp_tab[i], reg_rdata);
      end
      "pad": begin
        drive_cycle(1'b0, ADDR_STATUS, '0, pad_tab[i], data_tab[i][0]);
        case (addr_tab[i])
          32'd0:   act = 32'(pad_out);
          32'd1:   act = 32'(pad_oe);
          default: act = {29'b0, jtag_tdi, jtag_tms, jtag_tck};  // Debug port bits
        endcase
        check_value(name_tab[i], exp_tab[i], act);
      end
      "wait": begin
        if (data_tab[i] == 0) begin
          wait_idle(name_tab[i], pad_tab[i]);
        end else begin
          repeat (data_tab[i]) drive_cycle(1'b0, ADDR_STATUS, '0, pad_tab[i], 1'b0);
        end
      end
      "rand": run_random(name_tab[i]);
      default: begin
        $display("%0s: unknown operation in the stimulus file", name_tab[i]);
        n_errors++;
        test_ok = 1'b0;
      end
    endcase
    n_tests++;
    if (test_ok) begin
      $display("ok   %0s", name_tab[i]);
    end else begin
      $display("bad  %0s", name_tab[i]);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    rst       = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = ADDR_GPIO_OUT;
    reg_wdata = '0;
    pad_in    = '0;
    jtag_tdo  = 1'b0;
    void'($urandom(56120));
    load_stimulus();
    if (n_lines == 0) begin
      $display("No stimulus lines were read, nothing was tested");
      n_errors++;
    end else begin
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_lines; i++) begin
        run_line(i);
      end
    end
    n_errors += dut_i.u_board_top_assert.fail_cnt;
    $display("Tests %0d, errors %0d, assertion failures %0d", n_tests, n_errors,
             dut_i.u_board_top_assert.fail_cnt);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Budget of one full cipher run per stimulus line, plus reset
  initial begin : watchdog
    wait (n_lines > 0);
    #((n_lines + 4) * poll_limit * clk_period);
    $display("Timeout, the stimulus did not complete in the allotted time");
    $display("Some tests failed");
    $finish;
  end

endmodule : tb_board_top

/* run.sh */
#!/usr/bin/env bash
# Build and run the board_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_board_top -o sim_tb_board_top

# Error limit raised so assertion failures reach the closing report
./obj_dir/sim_tb_board_top +verilator+error+limit+100 | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

/* src.f */
+incdir+verilog
verilog/board_pkg.sv
verilog/jtag_overlay_mux.sv
verilog/round_engine.sv
verilog/soc_core.sv
verilog/board_top.sv
dv/board_top_assert.sv
dv/tb_board_top.sv

/* verilog/board_params.svh */
////////////////////
// Board sizes and fixed pad positions
// JTAG pads must sit above the trigger pad, TDO is the last pad
////////////////////

`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Pad row, 16 GPIOs followed by the JTAG group
`define BOARD_NUM_PADS    21

`define BOARD_TRIGGER_IDX 15  // Software capture trigger
`define BOARD_JTAG_EN_IDX 16  // Strap, high selects JTAG
`define BOARD_TCK_IDX     17
`define BOARD_TMS_IDX     18
`define BOARD_TDI_IDX     19
`define BOARD_TDO_IDX     20

// Register and cipher width
`define BOARD_DW          32

// Cipher rounds per start
`define BOARD_ROUNDS      8

`endif

/* verilog/board_pkg.sv */
////////////////////
// Register map and cipher FSM encodings shared by the core and the testbench
// Addresses are 3 bits, so the map holds exactly eight registers
////////////////////

package board_pkg;

  ////////////////////
  // Register map
  ////////////////////

  typedef enum logic [2:0] {
    ADDR_GPIO_OUT = 3'd0,  // RW, low pad-count bits used
    ADDR_GPIO_OE  = 3'd1,  // RW, low pad-count bits used
    ADDR_KEY      = 3'd2,  // RW, locked while busy
    ADDR_DATA     = 3'd3,  // RW, locked while busy
    ADDR_CTRL     = 3'd4,  // W, bit 0 starts the cipher
    ADDR_RESULT   = 3'd5,  // RO
    ADDR_GPIO_IN  = 3'd6,  // RO, core-side pad inputs
    ADDR_STATUS   = 3'd7   // RO, bit 0 is idle
  } reg_addr_e;

  ////////////////////
  // Cipher FSM
  ////////////////////

  // DONE counts as idle and marks a valid result
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } cipher_state_e;

endpackage : board_pkg

/* verilog/board_top.sv */
////////////////////
// Pads are split into in, out and enable vectors, no tristates
// Trigger pad only toggles while the cipher is busy
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module board_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Pads
  input  logic [`BOARD_NUM_PADS-1:0] pad_in_i,
  output logic [`BOARD_NUM_PADS-1:0] pad_out_o,
  output logic [`BOARD_NUM_PADS-1:0] pad_oe_o,
  // Register port
  input  logic                       reg_we_i,
  input  board_pkg::reg_addr_e       reg_addr_i,
  input  logic [`BOARD_DW-1:0]       reg_wdata_i,
  output logic [`BOARD_DW-1:0]       reg_rdata_o,
  // Debug port
  output logic                       jtag_tck_o,
  output logic                       jtag_tms_o,
  output logic                       jtag_tdi_o,
  input  logic                       jtag_tdo_i
);

  logic [`BOARD_NUM_PADS-1:0] core_out;
  logic [`BOARD_NUM_PADS-1:0] core_out_trig;
  logic [`BOARD_NUM_PADS-1:0] core_oe;
  logic [`BOARD_NUM_PADS-1:0] core_in;
  logic                       cipher_idle;

  soc_core u_soc_core (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .reg_we_i      ( reg_we_i    ),
    .reg_addr_i    ( reg_addr_i  ),
    .reg_wdata_i   ( reg_wdata_i ),
    .reg_rdata_o   ( reg_rdata_o ),
    .gpio_in_i     ( core_in     ),
    .gpio_out_o    ( core_out    ),
    .gpio_oe_o     ( core_oe     ),
    .cipher_idle_o ( cipher_idle )
  );

  ////////////////////
  // Capture trigger
  ////////////////////

  // Software trigger is qualified by cipher busy for a tight scope window
  always_comb begin
    core_out_trig = core_out;
    core_out_trig[`BOARD_TRIGGER_IDX] = core_out[`BOARD_TRIGGER_IDX] & ~cipher_idle;
  end

  jtag_overlay_mux u_jtag_overlay_mux (
    .jtag_tck_o ( jtag_tck_o    ),
    .jtag_tms_o ( jtag_tms_o    ),
    .jtag_tdi_o ( jtag_tdi_o    ),
    .jtag_tdo_i ( jtag_tdo_i    ),
    .core_out_i ( core_out_trig ),
    .core_oe_i  ( core_oe       ),
    .core_in_o  ( core_in       ),
    .pad_in_i   ( pad_in_i      ),
    .pad_out_o  ( pad_out_o     ),
    .pad_oe_o   ( pad_oe_o      )
  );

endmodule : board_top

/* verilog/jtag_overlay_mux.sv */
////////////////////
// Purely combinational, strap pad is sampled without synchronizer
// Pads outside the JTAG group always pass straight through
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module jtag_overlay_mux (
  // Debug side
  output logic                       jtag_tck_o,
  output logic                       jtag_tms_o,
  output logic                       jtag_tdi_o,
  input  logic                       jtag_tdo_i,
  // Core side
  input  logic [`BOARD_NUM_PADS-1:0] core_out_i,
  input  logic [`BOARD_NUM_PADS-1:0] core_oe_i,
  output logic [`BOARD_NUM_PADS-1:0] core_in_o,
  // Pad side
  input  logic [`BOARD_NUM_PADS-1:0] pad_in_i,
  output logic [`BOARD_NUM_PADS-1:0] pad_out_o,
  output logic [`BOARD_NUM_PADS-1:0] pad_oe_o
);

  // Pads taken over by the overlay
  localparam logic [`BOARD_NUM_PADS-1:0] jtag_mask =
      (`BOARD_NUM_PADS'(1) << `BOARD_TCK_IDX) |
      (`BOARD_NUM_PADS'(1) << `BOARD_TMS_IDX) |
      (`BOARD_NUM_PADS'(1) << `BOARD_TDI_IDX) |
      (`BOARD_NUM_PADS'(1) << `BOARD_TDO_IDX);

  // Core sees TMS high, everything else low
  localparam logic [`BOARD_NUM_PADS-1:0] tie_off = `BOARD_NUM_PADS'(1) << `BOARD_TMS_IDX;

  logic jtag_en;

  assign jtag_en = pad_in_i[`BOARD_JTAG_EN_IDX];

  ////////////////////
  // Debug port
  ////////////////////

  // Rest values when the strap is low
  assign jtag_tck_o = jtag_en ? pad_in_i[`BOARD_TCK_IDX] : 1'b0;
  assign jtag_tms_o = jtag_en ? pad_in_i[`BOARD_TMS_IDX] : 1'b1;
  assign jtag_tdi_o = jtag_en ? pad_in_i[`BOARD_TDI_IDX] : 1'b0;

  ////////////////////
  // Pad overlay
  ////////////////////

  always_comb begin
    core_in_o = pad_in_i;
    pad_out_o = core_out_i;
    pad_oe_o  = core_oe_i;

    if (jtag_en) begin
      // Hide the JTAG pads from the core
      core_in_o = (pad_in_i & ~jtag_mask) | tie_off;

      // TCK, TMS and TDI are inputs only
      pad_oe_o[`BOARD_TCK_IDX] = 1'b0;
      pad_oe_o[`BOARD_TMS_IDX] = 1'b0;
      pad_oe_o[`BOARD_TDI_IDX] = 1'b0;

      pad_out_o[`BOARD_TDO_IDX] = jtag_tdo_i;
      pad_oe_o[`BOARD_TDO_IDX]  = 1'b1;  // Always driven in JTAG mode
    end
  end

endmodule : jtag_overlay_mux

/* verilog/round_engine.sv */
////////////////////
// Toy rotate-XOR cipher, not cryptographically meaningful
// Key must stay stable while busy, start is ignored while running
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module round_engine (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  logic [`BOARD_DW-1:0] key_i,
  input  logic [`BOARD_DW-1:0] data_i,
  output logic                 idle_o,
  output logic [`BOARD_DW-1:0] result_o
);

  import board_pkg::*;

  localparam int cnt_w = $clog2(`BOARD_ROUNDS);
  localparam logic [cnt_w-1:0] last_round = cnt_w'(`BOARD_ROUNDS - 1);

  cipher_state_e        fsm_q;
  logic [cnt_w-1:0]     round_q;
  logic [`BOARD_DW-1:0] state_q;
  logic [`BOARD_DW-1:0] state_mixed;
  logic [`BOARD_DW-1:0] state_next;
  logic [`BOARD_DW-1:0] result_q;
  logic                 load;

  // One round, XOR with key then rotate left by one
  assign state_mixed = state_q ^ key_i;
  assign state_next  = {state_mixed[`BOARD_DW-2:0], state_mixed[`BOARD_DW-1]};

  assign idle_o   = (fsm_q != ST_RUN);
  assign load     = start_i & idle_o;
  assign result_o = result_q;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fsm_q    <= ST_IDLE;
      round_q  <= '0;
      result_q <= '0;
    end else begin
      case (fsm_q)
        ST_IDLE, ST_DONE: begin
          if (load) begin
            fsm_q   <= ST_RUN;
            round_q <= '0;
          end
        end
        ST_RUN: begin
          round_q <= round_q + 1'b1;
          if (round_q == last_round) begin
            fsm_q    <= ST_DONE;
            result_q <= state_next;  // Final round goes straight to RESULT
          end
        end
        default: fsm_q <= ST_IDLE;
      endcase
    end
  end

  // Working state, loaded on start and stepped once per cycle
  always_ff @(posedge clk_i) begin
    if (load) begin
      state_q <= data_i;
    end else if (fsm_q == ST_RUN) begin
      state_q <= state_next;
    end
  end

endmodule : round_engine

/* verilog/soc_core.sv */
////////////////////
// Register bank, one write and one combinational read per cycle
// KEY and DATA are write-protected while the cipher runs
////////////////////

`timescale 1ns/10ps

`include "board_params.svh"

module soc_core (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Register port
  input  logic                       reg_we_i,
  input  board_pkg::reg_addr_e       reg_addr_i,
  input  logic [`BOARD_DW-1:0]       reg_wdata_i,
  output logic [`BOARD_DW-1:0]       reg_rdata_o,
  // GPIO
  input  logic [`BOARD_NUM_PADS-1:0] gpio_in_i,
  output logic [`BOARD_NUM_PADS-1:0] gpio_out_o,
  output logic [`BOARD_NUM_PADS-1:0] gpio_oe_o,
  // Cipher status
  output logic                       cipher_idle_o
);

  import board_pkg::*;

  localparam int pad_gap = `BOARD_DW - `BOARD_NUM_PADS;

  logic [`BOARD_NUM_PADS-1:0] gpio_out_q;
  logic [`BOARD_NUM_PADS-1:0] gpio_oe_q;
  logic [`BOARD_DW-1:0]       key_q;
  logic [`BOARD_DW-1:0]       data_q;
  logic [`BOARD_DW-1:0]       result;
  logic                       cipher_idle;
  logic                       start;

  ////////////////////
  // Write side
  ////////////////////

  // Start pulse lasts exactly the cycle of the CTRL write
  assign start = reg_we_i && (reg_addr_i == ADDR_CTRL) && reg_wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      key_q      <= '0;
      data_q     <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        ADDR_GPIO_OUT: gpio_out_q <= reg_wdata_i[`BOARD_NUM_PADS-1:0];
        ADDR_GPIO_OE:  gpio_oe_q  <= reg_wdata_i[`BOARD_NUM_PADS-1:0];
        ADDR_KEY: begin
          if (cipher_idle) begin
            key_q <= reg_wdata_i;
          end
        end
        ADDR_DATA: begin
          if (cipher_idle) begin
            data_q <= reg_wdata_i;
          end
        end
        default: ;  // CTRL only pulses, the rest are read only
      endcase
    end
  end

  assign gpio_out_o = gpio_out_q;
  assign gpio_oe_o  = gpio_oe_q;

  ////////////////////
  // Cipher
  ////////////////////

  round_engine u_round_engine (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .start_i  ( start       ),
    .key_i    ( key_q       ),
    .data_i   ( data_q      ),
    .idle_o   ( cipher_idle ),
    .result_o ( result      )
  );

  assign cipher_idle_o = cipher_idle;

  // Readback
  always_comb begin
    case (reg_addr_i)
      ADDR_GPIO_OUT: reg_rdata_o = {{pad_gap{1'b0}}, gpio_out_q};
      ADDR_GPIO_OE:  reg_rdata_o = {{pad_gap{1'b0}}, gpio_oe_q};
      ADDR_KEY:      reg_rdata_o = key_q;
      ADDR_DATA:     reg_rdata_o = data_q;
      ADDR_RESULT:   reg_rdata_o = result;
      ADDR_GPIO_IN:  reg_rdata_o = {{pad_gap{1'b0}}, gpio_in_i};
      ADDR_STATUS:   reg_rdata_o = {{(`BOARD_DW-1){1'b0}}, cipher_idle};
      default:       reg_rdata_o = '0;  // CTRL reads as zero
    endcase
  end

endmodule : soc_core
